//--- dsp_pkg.sv
`default_nettype none

package dsp_pkg;

    // ##################################################
    // Widths

    localparam int channel_width    = 4;     // Interleaved channels per block
    localparam int ffe_length       = 4;     // Taps per channel
    localparam int code_precision   = 8;
    localparam int weight_precision = 8;
    localparam int est_precision    = 12;
    localparam int prod_precision   = code_precision + weight_precision;
    localparam int sum_precision    = prod_precision + $clog2(ffe_length);

    // ##################################################
    // Fixed constants

    localparam int ffe_shift    = 4;        // Arithmetic right shift before saturation
    localparam int target_level = 64;       // Ideal equalized magnitude

    localparam int est_max    = 2**(est_precision-1) - 1;
    localparam int est_min    = -(2**(est_precision-1));
    localparam int weight_max = 2**(weight_precision-1) - 1;
    localparam int weight_min = -(2**(weight_precision-1));

    // ##################################################
    // Types

    typedef logic signed [code_precision-1:0]   code_t;
    typedef logic signed [weight_precision-1:0] weight_t;
    typedef logic signed [est_precision-1:0]    est_t;
    typedef logic signed [prod_precision-1:0]   prod_t;
    typedef logic signed [sum_precision-1:0]    sum_t;
    typedef logic signed [est_precision:0]      err_t;    // One extra bit for the target offset

    typedef code_t [channel_width-1:0] adc_block_t;                        // One input beat
    typedef code_t [2*channel_width-1:0] window_t;                         // Previous block low
    typedef weight_t [ffe_length-1:0][channel_width-1:0] weight_set_t;     // Tap by channel
    typedef est_t [channel_width-1:0] est_block_t;

    typedef struct packed {
        est_block_t               est;
        logic [channel_width-1:0] bits;    // A sliced decision is 1 for an estimate of 0 or more
    } eq_out_t;

    // Only the cursor tap starts nonzero
    localparam weight_t init_tap0 = 16;

    localparam weight_set_t init_weights = {
        {(ffe_length-1)*channel_width{weight_t'(0)}},
        {channel_width{init_tap0}}
    };

endpackage

`default_nettype wire

//--- pipe_stage.sv
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic reset_i,

    // Upstream side
    input  wire logic valid_i,
    input  payload_t  data_i,
    output logic      ready_o,

    // Downstream side
    output logic      valid_o,
    output payload_t  data_o,
    input  wire logic ready_i
);

    logic     valid_q;
    payload_t data_q;

    // Accept when empty or when the held item leaves on this edge
    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;    // Drains to empty when nothing new arrives
        end
    end

    always_ff @(posedge clk) begin
        if (ready_o && valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

//--- comb_ffe.sv
`default_nettype none

module comb_ffe
    import dsp_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset_i,
    input  wire logic  advance_i,
    input  adc_block_t codes_i,
    input  weight_set_t weights_i,
    output est_block_t est_o,
    output adc_block_t hist_o
);

    adc_block_t hist_q;
    window_t    window;

    // ##################################################
    // History of the previous accepted block

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hist_q <= '0;
        end else if (advance_i) begin
            hist_q <= codes_i;
        end
    end

    assign hist_o = hist_q;

    // Window index channel_width + j is the current sample j
    assign window = {codes_i, hist_q};

    // ##################################################
    // Per-channel multiply-accumulate

    for (genvar j = 0; j < channel_width; j++) begin : g_chan
        prod_t prod;
        sum_t  acc;
        sum_t  shifted;

        always_comb begin
            acc = '0;
            for (int k = 0; k < ffe_length; k++) begin
                prod = weights_i[k][j] * window[channel_width + j - k];    // Tap k reaches k back
                acc  = acc + prod;
            end
        end

        assign shifted = acc >>> ffe_shift;

        // Saturate to the estimate range
        always_comb begin
            if (shifted > est_max) begin
                est_o[j] = est_t'(est_max);
            end else if (shifted < est_min) begin
                est_o[j] = est_t'(est_min);
            end else begin
                est_o[j] = est_t'(shifted);
            end
        end
    end

endmodule

`default_nettype wire

//--- fir_adapter.sv
`default_nettype none

module fir_adapter
    import dsp_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   advance_i,
    input  wire logic   adapt_en_i,
    input  wire logic   load_init_i,
    input  adc_block_t  codes_i,
    input  adc_block_t  hist_i,
    input  est_block_t  est_i,
    output weight_set_t weights_o
);

    window_t                  window;
    logic [channel_width-1:0] err_neg;
    logic [channel_width-1:0] err_zero;
    weight_set_t              weights_q;
    weight_set_t              weights_step;

    // Same sample window that the FFE used for these estimates
    assign window = {codes_i, hist_i};

    // ##################################################
    // Slicer error per channel

    for (genvar j = 0; j < channel_width; j++) begin : g_err
        err_t err;

        always_comb begin
            if (est_i[j] >= 0) begin
                err = err_t'(est_i[j]) - err_t'(target_level);
            end else begin
                err = err_t'(est_i[j]) + err_t'(target_level);
            end
        end

        assign err_neg[j]  = err[est_precision];
        assign err_zero[j] = (err == '0);
    end

    // ##################################################
    // Sign-sign LMS step

    always_comb begin
        weights_step = weights_q;
        for (int k = 0; k < ffe_length; k++) begin
            for (int j = 0; j < channel_width; j++) begin
                if (!err_zero[j]) begin
                    // Equal signs give a positive product, so step down
                    if (err_neg[j] == window[channel_width + j - k][code_precision-1]) begin
                        if (weights_q[k][j] != weight_t'(weight_min)) begin
                            weights_step[k][j] = weights_q[k][j] - weight_t'(1);
                        end
                    end else begin
                        if (weights_q[k][j] != weight_t'(weight_max)) begin
                            weights_step[k][j] = weights_q[k][j] + weight_t'(1);
                        end
                    end
                end
            end
        end
    end

    // ##################################################
    // Weight register file

    always_ff @(posedge clk) begin
        if (reset_i || load_init_i) begin
            weights_q <= init_weights;    // Load-init wins over adaptation
        end else if (advance_i && adapt_en_i) begin
            weights_q <= weights_step;
        end
    end

    assign weights_o = weights_q;

endmodule

`default_nettype wire

//--- dsp_equalizer.sv
`default_nettype none

module dsp_equalizer
    import dsp_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,

    // Input blocks
    input  wire logic   in_valid_i,
    input  adc_block_t  in_data_i,
    output logic        in_ready_o,

    // Equalized output
    output logic        out_valid_o,
    output eq_out_t     out_data_o,
    input  wire logic   out_ready_i,

    // Adaptation control
    input  wire logic   adapt_en_i,
    input  wire logic   load_init_i,
    output weight_set_t weights_o
);

    logic        a_valid;
    adc_block_t  a_data;
    logic        b_ready;
    logic        advance;
    est_block_t  est;
    adc_block_t  hist;
    eq_out_t     eq_out;
    weight_set_t weights;

    // ##################################################
    // Stage A holds the block being equalized

    pipe_stage #(
        .payload_t (adc_block_t)
    ) u_stage_a (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (in_valid_i),
        .data_i  (in_data_i),
        .ready_o (in_ready_o),
        .valid_o (a_valid),
        .data_o  (a_data),
        .ready_i (b_ready)
    );

    // History, weights and stage B all move on this one edge
    assign advance = a_valid && b_ready;

    comb_ffe u_comb_ffe (
        .clk       (clk),
        .reset_i   (reset_i),
        .advance_i (advance),
        .codes_i   (a_data),
        .weights_i (weights),
        .est_o     (est),
        .hist_o    (hist)
    );

    fir_adapter u_fir_adapter (
        .clk         (clk),
        .reset_i     (reset_i),
        .advance_i   (advance),
        .adapt_en_i  (adapt_en_i),
        .load_init_i (load_init_i),
        .codes_i     (a_data),
        .hist_i      (hist),
        .est_i       (est),
        .weights_o   (weights)
    );

    always_comb begin
        eq_out.est = est;
        for (int j = 0; j < channel_width; j++) begin
            eq_out.bits[j] = ~est[j][est_precision-1];    // Zero slices to 1
        end
    end

    // ##################################################
    // Stage B holds the result

    pipe_stage #(
        .payload_t (eq_out_t)
    ) u_stage_b (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (a_valid),
        .data_i  (eq_out),
        .ready_o (b_ready),
        .valid_o (out_valid_o),
        .data_o  (out_data_o),
        .ready_i (out_ready_i)
    );

    assign weights_o = weights;

endmodule

`default_nettype wire

//--- dsp_equalizer_props.sv
`default_nettype none

module dsp_equalizer_props
    import dsp_pkg::*;
(
    input wire logic       clk,
    input wire logic       reset_i,
    input wire logic       in_valid_i,
    input wire adc_block_t in_data_i,
    input wire logic       in_ready_i,
    input wire logic       out_valid_i,
    input wire eq_out_t    out_data_i,
    input wire logic       out_ready_i,
    input wire logic       a_valid_i
);

    // ##################################################
    // Handshake stability

    in_hold: assert property (@(posedge clk) disable iff (reset_i)
        in_valid_i && !in_ready_i |=> in_valid_i && $stable(in_data_i))
        else $error("Input beat dropped or changed before it was accepted");

    out_hold: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
        else $error("Output beat dropped or changed while stalled");

    // ##################################################
    // Reset and empty-stage behavior

    reset_clears_out: assert property (@(posedge clk)
        reset_i |=> !out_valid_i)
        else $error("Output valid high during or right after reset");

    empty_accepts: assert property (@(posedge clk) disable iff (reset_i)
        !a_valid_i |-> in_ready_i)
        else $error("Input ready low while stage A is empty");

endmodule

bind dsp_equalizer dsp_equalizer_props u_props (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o),
    .out_data_i  (out_data_o),
    .out_ready_i (out_ready_i),
    .a_valid_i   (a_valid)
);

`default_nettype wire

//--- tb_dsp_equalizer.sv
`default_nettype none

module tb_dsp_equalizer
    import dsp_pkg::*;
();

    localparam int clk_period      = 4;
    localparam int total_beats     = 964;
    localparam int cycles_per_beat = 40;    // Worst-case stall bound for one beat
    localparam int watchdog_time   = (total_beats * cycles_per_beat + 500) * clk_period;

    localparam int code_random = 0;
    localparam int code_small  = 1;
    localparam int code_full   = 2;

    localparam int est_hi  = (1 << (est_precision - 1)) - 1;
    localparam int est_lo  = -(1 << (est_precision - 1));
    localparam int w_hi    = (1 << (weight_precision - 1)) - 1;
    localparam int w_lo    = -(1 << (weight_precision - 1));
    localparam int code_hi = (1 << (code_precision - 1)) - 1;
    localparam int code_lo = -(1 << (code_precision - 1));

    logic        clk;
    logic        reset_i;
    logic        in_valid_i;
    adc_block_t  in_data_i;
    logic        in_ready_o;
    logic        out_valid_o;
    eq_out_t     out_data_o;
    logic        out_ready_i;
    logic        adapt_en_i;
    logic        load_init_i;
    weight_set_t weights_o;

    adc_block_t  sent_q[$];
    int          in_edge_q[$];
    adc_block_t  model_hist;
    weight_set_t model_w;
    int          edge_count;
    int          sent_total;
    int          rcv_count;
    int          error_count;
    int          sat_hi;
    int          sat_lo;
    bit          in_fire;
    bit          latency_check;
    int          gap_pct;
    int          stall_pct;

    dsp_equalizer u_dsp_equalizer (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i),
        .adapt_en_i  (adapt_en_i),
        .load_init_i (load_init_i),
        .weights_o   (weights_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_time);
        abort_run($sformatf("Timeout after %0d time units with %0d of %0d beats received",
                            watchdog_time, rcv_count, total_beats));
    end

    // ##################################################
    // Reference model

    function automatic int clip_range(input int val, input int lo, input int hi);
        if (val > hi) begin
            return hi;
        end else if (val < lo) begin
            return lo;
        end
        return val;
    endfunction

    // Negative index reaches back into the previous block
    function automatic int sample_at(input adc_block_t codes, input adc_block_t hist, input int idx);
        if (idx < 0) begin
            return int'($signed(hist[channel_width + idx]));
        end
        return int'($signed(codes[idx]));
    endfunction

    function automatic int weight_of(input weight_set_t w, input int k, input int j);
        return int'($signed(w[k][j]));
    endfunction

    function automatic weight_set_t reset_weights();
        weight_set_t w;
        w = '0;
        for (int j = 0; j < channel_width; j++) begin
            w[0][j] = weight_t'(16);    // Cursor tap only
        end
        return w;
    endfunction

    function automatic est_block_t ffe_estimate(input adc_block_t codes, input adc_block_t hist,
                                                input weight_set_t w);
        est_block_t est;
        int         acc;
        for (int j = 0; j < channel_width; j++) begin
            acc = 0;
            for (int k = 0; k < ffe_length; k++) begin
                acc += weight_of(w, k, j) * sample_at(codes, hist, j - k);
            end
            acc = acc >>> ffe_shift;
            est[j] = est_t'(clip_range(acc, est_lo, est_hi));
        end
        return est;
    endfunction

    function automatic weight_set_t lms_update(input adc_block_t codes, input adc_block_t hist,
                                               input est_block_t est, input weight_set_t w);
        weight_set_t next_w;
        int          err;
        int          step;
        next_w = w;
        for (int j = 0; j < channel_width; j++) begin
            err = int'($signed(est[j]));
            err = (err >= 0) ? err - target_level : err + target_level;
            if (err != 0) begin
                for (int k = 0; k < ffe_length; k++) begin
                    // Step against the product of the error sign and the code sign
                    step = ((err > 0) == (sample_at(codes, hist, j - k) >= 0)) ? -1 : 1;
                    next_w[k][j] = weight_t'(clip_range(weight_of(w, k, j) + step, w_lo, w_hi));
                end
            end
        end
        return next_w;
    endfunction

    // ##################################################
    // Checks and stimulus

    task automatic abort_run(input string why);
        error_count++;
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic adc_block_t random_block(input int code_mode);
        adc_block_t blk;
        for (int j = 0; j < channel_width; j++) begin
            case (code_mode)
                code_small: blk[j] = code_t'(1);
                code_full:  blk[j] = ($urandom_range(1) == 1) ? code_t'(code_hi) : code_t'(code_lo);
                default:    blk[j] = code_t'($urandom_range(255));
            endcase
        end
        return blk;
    endfunction

    task automatic stream_blocks(input int num_beats, input int code_mode);
        int sent;
        sent = 0;
        while (sent < num_beats || in_valid_i) begin
            @(negedge clk);
            out_ready_i = ($urandom_range(99) >= stall_pct);
            if (!in_valid_i || in_fire) begin
                if (sent < num_beats && $urandom_range(99) >= gap_pct) begin
                    in_valid_i = 1'b1;
                    in_data_i  = random_block(code_mode);
                    sent++;
                end else begin
                    in_valid_i = 1'b0;
                end
            end
        end
        sent_total += num_beats;
        while (rcv_count < sent_total) begin    // Drain so the controls can change safely
            @(negedge clk);
            out_ready_i = ($urandom_range(99) >= stall_pct);
        end
    endtask

    task automatic pulse_load_init();
        @(negedge clk);
        load_init_i = 1'b1;
        @(negedge clk);
        load_init_i = 1'b0;
        model_w = reset_weights();
        @(negedge clk);
        check_value("weights_o", weights_o, model_w);
    endtask

    always @(posedge clk) begin : monitor
        adc_block_t               blk;
        int                       in_edge;
        est_block_t               exp_est;
        logic [channel_width-1:0] exp_bits;
        edge_count++;
        if (!reset_i && out_valid_o && out_ready_i) begin
            if (sent_q.size() == 0) begin
                abort_run("An output beat arrived with no input block in flight");
            end
            blk     = sent_q.pop_front();
            in_edge = in_edge_q.pop_front();
            exp_est = ffe_estimate(blk, model_hist, model_w);
            for (int j = 0; j < channel_width; j++) begin
                exp_bits[j] = ($signed(exp_est[j]) >= 0);
                check_value($sformatf("out_data_o.est[%0d]", j),
                            {out_data_o.est[j]}, {exp_est[j]});
                if (exp_est[j] == est_t'(est_hi)) begin
                    sat_hi++;
                end
                if (exp_est[j] == est_t'(est_lo)) begin
                    sat_lo++;
                end
            end
            check_value("out_data_o.bits", out_data_o.bits, exp_bits);
            if (adapt_en_i) begin
                model_w = lms_update(blk, model_hist, exp_est, model_w);
            end
            model_hist = blk;
            check_value("weights_o", weights_o, model_w);    // Already holds this block's update
            if (latency_check) begin
                check_value("output latency in edges", edge_count - in_edge, 2);
            end
            rcv_count++;
        end
        in_fire = !reset_i && in_valid_i && in_ready_o;
        if (in_fire) begin
            sent_q.push_back(in_data_i);
            in_edge_q.push_back(edge_count);
        end
    end

    initial begin
        void'($urandom(32'hf0f7_09d3));
        reset_i       = 1'b1;
        in_valid_i    = 1'b0;
        in_data_i     = '0;
        out_ready_i   = 1'b0;
        adapt_en_i    = 1'b0;
        load_init_i   = 1'b0;
        model_hist    = '0;
        model_w       = reset_weights();
        edge_count    = 0;
        sent_total    = 0;
        rcv_count     = 0;
        error_count   = 0;
        sat_hi        = 0;
        sat_lo        = 0;
        in_fire       = 1'b0;
        latency_check = 1'b0;
        gap_pct       = 0;
        stall_pct     = 0;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;
        check_value("weights_o", weights_o, model_w);
        check_value("in_ready_o", in_ready_o, 1'b1);

        // Full throughput with fixed weights, so every beat takes exactly two edges
        latency_check = 1'b1;
        stream_blocks(64, code_random);
        latency_check = 1'b0;

        gap_pct   = 25;
        stall_pct = 30;
        stream_blocks(200, code_random);
        adapt_en_i = 1'b1;
        stream_blocks(200, code_random);
        pulse_load_init();
        stream_blocks(100, code_random);

        // Tiny codes keep every error negative, so all weights climb to the top
        gap_pct   = 0;
        stall_pct = 0;
        stream_blocks(300, code_small);
        adapt_en_i = 1'b0;
        gap_pct    = 25;
        stall_pct  = 30;
        sat_hi     = 0;
        sat_lo     = 0;
        stream_blocks(100, code_full);
        if (sat_hi == 0 || sat_lo == 0) begin
            abort_run("Full-scale codes never drove an estimate to its saturation limit");
        end

        // With the output open any duplicated beat would still show up here
        out_ready_i = 1'b1;
        repeat (4) @(negedge clk);
        check_value("out_valid_o", out_valid_o, 1'b0);

        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
dsp_pkg.sv
pipe_stage.sv
comb_ffe.sv
fir_adapter.sv
dsp_equalizer.sv
dsp_equalizer_props.sv
tb_dsp_equalizer.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dsp_equalizer \
		-f sources.f --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
